/* files.f */
rtl/scope_pkg.sv
rtl/adc_bank_unpack.sv
rtl/acq_trigger.sv
rtl/frame_fifo.sv
rtl/cmd_engine.sv
rtl/tx_stream.sv
rtl/scope_top.sv
tb/tb_scope.sv

/* run.sh */
#!/bin/sh
# build and run the scope capture testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_scope -f files.f -o sim

out=$(./obj_dir/sim)
echo "$out"
echo "$out" | grep -q "^Test passed$"

/* tb/tb_scope.sv */
// random-stimulus testbench for scope_top with a frame model; top module of the simulation
`default_nettype none

module tb_scope;
	import scope_pkg::*;

	localparam int TIMEOUT_CYCLES = 20000;
	localparam int WAIT_LIMIT     = 600;    // per transfer under back-pressure

	logic                       clk;
	logic                       rstn;
	bank_bits_t [NUM_BANKS-1:0] bank_bits;
	logic                       i_cmd_valid;
	byte_t                      i_cmd_data;
	wire                        o_cmd_ready;
	wire                        o_tx_valid;
	logic                       i_tx_ready;
	wire word_t                 o_tx_data;
	wire [3:0]                  o_tx_keep;
	wire                        o_tx_last;

	int         cycles = 0;
	int         checks = 0;
	int         errors = 0;
	int         test_errors = 0;
	word_t      model_words [FRAME_WORDS];
	word_t      rx_data [$];
	logic [3:0] rx_keep [$];
	logic       rx_last [$];

	scope_top dut (
		.clk         (clk),
		.rstn        (rstn),
		.i_bank_bits (bank_bits),
		.i_cmd_valid (i_cmd_valid),
		.i_cmd_data  (i_cmd_data),
		.o_cmd_ready (o_cmd_ready),
		.o_tx_valid  (o_tx_valid),
		.i_tx_ready  (i_tx_ready),
		.o_tx_data   (o_tx_data),
		.o_tx_keep   (o_tx_keep),
		.o_tx_last   (o_tx_last)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	// --------------------
	// checks and reporting
	task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			test_errors++;
			$display("Mismatch %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		test_errors++;
		$display("%s", msg);
	endtask

	task automatic end_test(input string name);
		$display("test %s finished with %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	// --------------------
	// stimulus
	task automatic drive_banks(input logic force_first, input sample_t first);
		int          g;
		int          i;
		logic [31:0] r;
		@(negedge clk);
		for (g = 0; g < NUM_BANKS; g++) begin
			for (i = 0; i < BANK_BITS; i++) begin
				r = $urandom;
				bank_bits[g][i] = r[0];
			end
		end
		if (force_first) begin
			for (i = 0; i < SAMPLE_W; i++) begin
				bank_bits[0][BANK_SAMPLES*i] = first[i];   // sample 0 of bank 0
			end
		end
	endtask

	task automatic send_command(input byte_t op, input byte_t arg, input len_t len);
		byte_t msg [CMD_BYTES];
		int    i;
		int    waited;
		for (i = 0; i < CMD_BYTES; i++) begin
			msg[i] = 8'd0;
		end
		msg[0] = op;
		msg[1] = arg;
		msg[4] = len[7:0];
		msg[5] = len[15:8];
		for (i = 0; i < CMD_BYTES; i++) begin
			waited = 0;
			@(negedge clk);
			i_cmd_valid = 1'b1;
			i_cmd_data  = msg[i];
			while (!o_cmd_ready && waited < WAIT_LIMIT) begin
				@(negedge clk);
				waited++;
			end
			if (!o_cmd_ready) begin
				report_error($sformatf("command byte %0d was never accepted", i));
			end
		end
		@(negedge clk);
		i_cmd_valid = 1'b0;
	endtask

	// words are sampled at the falling edge before their transfer edge
	task automatic collect_words(input string name, input int n);
		int waited;
		rx_data.delete();
		rx_keep.delete();
		rx_last.delete();
		waited = 0;
		while (rx_data.size() < n && waited < WAIT_LIMIT) begin
			@(negedge clk);
			i_tx_ready = ($urandom_range(99, 0) < 70);
			if (o_tx_valid && i_tx_ready) begin
				rx_data.push_back(o_tx_data);
				rx_keep.push_back(o_tx_keep);
				rx_last.push_back(o_tx_last);
				compare_value({name, " cmd ready"}, 32'd0, {31'd0, o_cmd_ready});
			end
			waited++;
		end
		@(negedge clk);
		i_tx_ready = 1'b0;
		if (rx_data.size() < n) begin
			report_error($sformatf("only %0d of %0d words arrived", rx_data.size(), n));
		end
	endtask

	task automatic expect_silence(input string name, input int n);
		int seen;
		seen = 0;
		repeat (n) begin
			@(negedge clk);
			i_tx_ready = 1'b1;
			if (o_tx_valid) begin
				seen++;
			end
		end
		i_tx_ready = 1'b0;
		compare_value(name, 0, seen);
	endtask

	// --------------------
	// model
	function automatic void build_model();
		sample_t s [FRAME_SAMPLES];
		int      g;
		int      k;
		int      b;
		int      w;
		for (g = 0; g < NUM_BANKS; g++) begin
			for (k = 0; k < BANK_SAMPLES; k++) begin
				for (b = 0; b < SAMPLE_W; b++) begin
					s[g*BANK_SAMPLES + k][b] = bank_bits[g][BANK_SAMPLES*b + k];
				end
			end
		end
		for (w = 0; w < FRAME_WORDS - 1; w++) begin
			model_words[w] = {4'd0, s[2*w + 1], 4'd0, s[2*w]};
		end
		model_words[FRAME_WORDS-1] = {16'hbeef, 16'hdead};   // end of frame
	endfunction

	// one keep bit for each byte still owed
	function automatic logic [3:0] keep_for(input int remain);
		logic [3:0] mask;
		int         i;
		for (i = 0; i < 4; i++) begin
			mask[i] = (i < remain);
		end
		return mask;
	endfunction

	task automatic check_reply(input string name, input logic [31:0] value);
		collect_words(name, 1);
		if (rx_data.size() == 1) begin
			compare_value({name, " data"}, value, rx_data[0]);
			compare_value({name, " keep"}, 32'hf, {28'd0, rx_keep[0]});
			compare_value({name, " last"}, 32'd1, {31'd0, rx_last[0]});
		end
	endtask

	task automatic check_read(input string name, input int len);
		int    i;
		int    remain;
		logic  exp_last;
		string tag;
		collect_words(name, (len + 3) / 4);
		for (i = 0; i < rx_data.size(); i++) begin
			remain   = len - 4*i;
			exp_last = (remain <= 4);
			tag      = $sformatf("%s word %0d", name, i);
			compare_value({tag, " data"}, model_words[i % FRAME_WORDS], rx_data[i]);
			compare_value({tag, " keep"}, {28'd0, keep_for(remain)}, {28'd0, rx_keep[i]});
			compare_value({tag, " last"}, {31'd0, exp_last}, {31'd0, rx_last[i]});
		end
	endtask

	// --------------------
	// tests
	initial begin
		void'($urandom(32'hfe3f));
		rstn        = 1'b0;
		i_cmd_valid = 1'b0;
		i_cmd_data  = 8'd0;
		i_tx_ready  = 1'b0;
		bank_bits   = '0;
		repeat (2) @(negedge clk);
		rstn = 1'b1;

		send_command(8'd2, 8'd0, 16'd0);
		check_reply("version", 32'd7);
		send_command(8'd4, 8'd0, 16'd0);
		check_reply("unused opcode", 32'd19);
		send_command(8'h09, 8'd0, 16'd0);
		expect_silence("unknown opcode reply words", 30);
		send_command(8'd2, 8'd0, 16'd0);
		check_reply("version again", 32'd7);
		end_test("version_and_unused");

		drive_banks(1'b0, '0);
		build_model();
		send_command(8'd5, 8'd0, 16'd2);
		send_command(8'd0, 8'd0, 16'd168);
		check_read("immediate", 168);
		end_test("immediate_capture");

		drive_banks(1'b1, 12'sd0);                 // inside the window
		send_command(8'd5, 8'd1, 16'd1);
		repeat (3) @(negedge clk);
		drive_banks(1'b1, -12'sd50);
		repeat (3) @(negedge clk);
		drive_banks(1'b1, 12'sd50);                // held until read
		build_model();
		send_command(8'd0, 8'd0, 16'd84);
		check_read("threshold", 84);
		end_test("threshold_trigger");

		drive_banks(1'b0, '0);
		build_model();
		send_command(8'd5, 8'd0, 16'd1);
		send_command(8'd0, 8'd0, 16'd10);
		check_read("partial", 10);
		end_test("partial_length");

		drive_banks(1'b0, '0);
		build_model();
		send_command(8'd5, 8'd0, 16'd6);
		send_command(8'd0, 8'd0, 16'd336);
		check_read("fifo full", 336);
		drive_banks(1'b0, '0);
		build_model();
		send_command(8'd5, 8'd0, 16'd1);
		send_command(8'd0, 8'd0, 16'd84);
		check_read("re-arm", 84);
		end_test("fifo_full_rearm");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/scope_top.sv */
// top level of the scope capture core; connects unpackers, trigger, frame FIFO, command and stream
`default_nettype none

module scope_top (
	input  wire                                              clk,
	input  wire                                              rstn,
	input  wire scope_pkg::bank_bits_t [scope_pkg::NUM_BANKS-1:0] i_bank_bits,
	input  wire                                              i_cmd_valid,
	input  wire scope_pkg::byte_t                            i_cmd_data,
	output wire                                              o_cmd_ready,
	output wire                                              o_tx_valid,
	input  wire                                              i_tx_ready,
	output wire scope_pkg::word_t                            o_tx_data,
	output wire [3:0]                                        o_tx_keep,
	output wire                                              o_tx_last
);
	import scope_pkg::*;

	wire frame_t adc_frame;     // all banks, sample 0 lowest
	wire frame_t wr_frame;
	wire frame_t head_frame;
	wire         fifo_wr;
	wire         fifo_rd;
	wire         fifo_full;
	wire         fifo_empty;
	wire         arm;
	wire byte_t  trig_type;
	wire len_t   take_count;
	wire         acq_idle;
	wire         reply_start;
	wire word_t  reply_word;
	wire         read_start;
	wire len_t   read_len;
	wire         tx_done;

	// --------------------
	// bank unpackers
	for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
		adc_bank_unpack u_unpack (
			.clk       (clk),
			.rstn      (rstn),
			.i_bits    (i_bank_bits[g]),
			.o_samples (adc_frame[g*BANK_BITS +: BANK_BITS])
		);
	end

	acq_trigger u_acq (
		.clk          (clk),
		.rstn         (rstn),
		.i_frame      (adc_frame),
		.i_arm        (arm),
		.i_trig_type  (trig_type),
		.i_take_count (take_count),
		.i_fifo_full  (fifo_full),
		.o_fifo_wr    (fifo_wr),
		.o_frame      (wr_frame),
		.o_idle       (acq_idle)
	);

	frame_fifo u_fifo (
		.clk     (clk),
		.rstn    (rstn),
		.i_wr    (fifo_wr),
		.i_frame (wr_frame),
		.i_rd    (fifo_rd),
		.o_frame (head_frame),
		.o_full  (fifo_full),
		.o_empty (fifo_empty)
	);

	cmd_engine u_cmd (
		.clk           (clk),
		.rstn          (rstn),
		.i_cmd_valid   (i_cmd_valid),
		.i_cmd_data    (i_cmd_data),
		.o_cmd_ready   (o_cmd_ready),
		.i_acq_idle    (acq_idle),
		.o_arm         (arm),
		.o_trig_type   (trig_type),
		.o_take_count  (take_count),
		.o_reply_start (reply_start),
		.o_reply_word  (reply_word),
		.o_read_start  (read_start),
		.o_read_len    (read_len),
		.i_tx_done     (tx_done)
	);

	tx_stream u_tx (
		.clk           (clk),
		.rstn          (rstn),
		.i_reply_start (reply_start),
		.i_reply_word  (reply_word),
		.i_read_start  (read_start),
		.i_read_len    (read_len),
		.o_tx_done     (tx_done),
		.i_fifo_empty  (fifo_empty),
		.i_frame       (head_frame),
		.o_fifo_rd     (fifo_rd),
		.o_tx_valid    (o_tx_valid),
		.i_tx_ready    (i_tx_ready),
		.o_tx_data     (o_tx_data),
		.o_tx_keep     (o_tx_keep),
		.o_tx_last     (o_tx_last)
	);

endmodule

`default_nettype wire

/* rtl/tx_stream.sv */
// output word sequencer; sends one-word replies or frame data with keep and last flags
`default_nettype none

module tx_stream (
	input  wire                    clk,
	input  wire                    rstn,
	input  wire                    i_reply_start,
	input  wire scope_pkg::word_t  i_reply_word,
	input  wire                    i_read_start,
	input  wire scope_pkg::len_t   i_read_len,
	output logic                   o_tx_done,
	input  wire                    i_fifo_empty,
	input  wire scope_pkg::frame_t i_frame,
	output logic                   o_fifo_rd,
	output logic                   o_tx_valid,
	input  wire                    i_tx_ready,
	output scope_pkg::word_t       o_tx_data,
	output logic [3:0]             o_tx_keep,
	output logic                   o_tx_last
);
	import scope_pkg::*;

	tx_state_t             state;
	len_t                  remain;     // bytes still owed
	word_t                 reply_q;
	frame_t                frame_q;    // shifts down one sample pair per word
	logic [WORD_IDX_W-1:0] word_idx;
	logic                  xfer;
	word_t                 pair_word;

	assign xfer      = o_tx_valid && i_tx_ready;
	assign o_fifo_rd = (state == TX_FETCH) && !i_fifo_empty;   // frame leaves on load
	assign pair_word = {4'd0, frame_q[SAMPLE_W +: SAMPLE_W], 4'd0, frame_q[0 +: SAMPLE_W]};

	always_comb begin
		if (state == TX_REPLY) begin
			o_tx_data = reply_q;
		end else if (word_idx == FRAME_WORDS - 1) begin
			o_tx_data = FRAME_MARKER;
		end else begin
			o_tx_data = pair_word;
		end
	end

	// --------------------
	// keep and last from the remaining count
	always_comb begin
		case (remain)
			16'd1:   o_tx_keep = 4'b0001;
			16'd2:   o_tx_keep = 4'b0011;
			16'd3:   o_tx_keep = 4'b0111;
			default: o_tx_keep = 4'b1111;
		endcase
	end

	assign o_tx_last = (remain <= 16'd4);

	always_ff @(posedge clk) begin
		if ((state == TX_IDLE) && i_reply_start) begin
			reply_q <= i_reply_word;
		end
		if (o_fifo_rd) begin
			frame_q <= i_frame;
		end else if ((state == TX_WORDS) && xfer) begin
			frame_q <= frame_q >> (2 * SAMPLE_W);
		end
	end

	// --------------------
	// sequencer
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state      <= TX_IDLE;
			remain     <= '0;
			word_idx   <= '0;
			o_tx_valid <= 1'b0;
			o_tx_done  <= 1'b0;
		end else begin
			o_tx_done <= 1'b0;
			case (state)
				TX_IDLE: begin
					if (i_reply_start) begin
						remain     <= 16'd4;        // reply is a single full word
						o_tx_valid <= 1'b1;
						state      <= TX_REPLY;
					end else if (i_read_start) begin
						remain <= i_read_len;
						if (i_read_len == '0) begin
							o_tx_done <= 1'b1;      // nothing to send
						end else begin
							state <= TX_FETCH;
						end
					end
				end

				TX_REPLY: begin
					if (xfer) begin
						o_tx_valid <= 1'b0;
						o_tx_done  <= 1'b1;
						remain     <= '0;
						state      <= TX_IDLE;
					end
				end

				TX_FETCH: begin
					if (!i_fifo_empty) begin
						word_idx   <= '0;
						o_tx_valid <= 1'b1;
						state      <= TX_WORDS;
					end
				end

				TX_WORDS: begin
					if (xfer) begin
						if (o_tx_last) begin
							o_tx_valid <= 1'b0;
							o_tx_done  <= 1'b1;
							remain     <= '0;
							state      <= TX_IDLE;   // rest of the frame is dropped
						end else begin
							remain <= remain - 16'd4;
							if (word_idx == FRAME_WORDS - 1) begin
								o_tx_valid <= 1'b0;
								state      <= TX_FETCH;
							end else begin
								word_idx <= word_idx + 1'b1;
							end
						end
					end
				end

				default: begin
					state <= TX_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/cmd_engine.sv */
// collects 8-byte host commands, decodes the opcode and starts replies, reads or acquisitions
`default_nettype none

module cmd_engine (
	input  wire                   clk,
	input  wire                   rstn,
	input  wire                   i_cmd_valid,
	input  wire scope_pkg::byte_t i_cmd_data,
	output logic                  o_cmd_ready,
	input  wire                   i_acq_idle,
	output logic                  o_arm,
	output scope_pkg::byte_t      o_trig_type,
	output scope_pkg::len_t       o_take_count,
	output logic                  o_reply_start,
	output scope_pkg::word_t      o_reply_word,
	output logic                  o_read_start,
	output scope_pkg::len_t       o_read_len,
	input  wire                   i_tx_done
);
	import scope_pkg::*;

	cmd_state_t                   state;
	byte_t                        rx_buf [CMD_BYTES];
	logic [$clog2(CMD_BYTES)-1:0] rx_cnt;
	logic                         rx_xfer;
	logic                         in_process;
	byte_t                        opcode;
	len_t                         msg_len;

	assign rx_xfer    = o_cmd_ready && i_cmd_valid;
	assign in_process = (state == CMD_PROCESS);
	assign opcode     = rx_buf[0];
	assign msg_len    = {rx_buf[5], rx_buf[4]};    // high byte 5

	// --------------------
	// decode, valid for the one cycle in CMD_PROCESS
	assign o_read_start  = in_process && (opcode == OP_READ);
	assign o_read_len    = msg_len;
	assign o_reply_start = in_process && ((opcode == OP_VERSION) || (opcode == OP_UNUSED));
	assign o_reply_word  = (opcode == OP_VERSION) ? FW_VERSION : UNUSED_REPLY;
	assign o_arm         = in_process && (opcode == OP_ARM) && i_acq_idle;
	assign o_trig_type   = rx_buf[1];
	assign o_take_count  = msg_len;

	always_ff @(posedge clk) begin
		if (rx_xfer) begin
			rx_buf[rx_cnt] <= i_cmd_data;
		end
	end

	// --------------------
	// control; ready is registered so it rises one cycle after reset
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= CMD_RX;
			rx_cnt      <= '0;
			o_cmd_ready <= 1'b0;
		end else begin
			case (state)
				CMD_RX: begin
					o_cmd_ready <= 1'b1;
					if (rx_xfer) begin
						rx_cnt <= rx_cnt + 1'b1;   // wraps to 0 after byte 7
						if (rx_cnt == CMD_BYTES - 1) begin
							state       <= CMD_PROCESS;
							o_cmd_ready <= 1'b0;
						end
					end
				end

				CMD_PROCESS: begin
					if (o_read_start || o_reply_start) begin
						state <= CMD_WAIT;
					end else begin
						state       <= CMD_RX;     // arm or unknown opcode
						o_cmd_ready <= 1'b1;
					end
				end

				CMD_WAIT: begin
					if (i_tx_done) begin
						state       <= CMD_RX;
						o_cmd_ready <= 1'b1;
					end
				end

				default: begin
					state <= CMD_RX;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/frame_fifo.sv */
// small FIFO of whole sample frames between the acquisition FSM and the output stream
`default_nettype none

module frame_fifo (
	input  wire                    clk,
	input  wire                    rstn,
	input  wire                    i_wr,
	input  wire scope_pkg::frame_t i_frame,
	input  wire                    i_rd,
	output scope_pkg::frame_t      o_frame,
	output logic                   o_full,
	output logic                   o_empty
);
	import scope_pkg::*;

	frame_t                mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W:0]   count;
	logic                  do_wr;
	logic                  do_rd;

	assign do_wr = i_wr && !o_full;     // writes to a full fifo are lost
	assign do_rd = i_rd && !o_empty;

	assign o_frame = mem[rd_ptr];        // head frame
	assign o_full  = (count == FIFO_DEPTH);
	assign o_empty = (count == '0);

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= i_frame;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/acq_trigger.sv */
// acquisition FSM; waits for the trigger, then writes captured frames into the frame FIFO
`default_nettype none

module acq_trigger (
	input  wire                    clk,
	input  wire                    rstn,
	input  wire scope_pkg::frame_t i_frame,
	input  wire                    i_arm,
	input  wire scope_pkg::byte_t  i_trig_type,
	input  wire scope_pkg::len_t   i_take_count,
	input  wire                    i_fifo_full,
	output logic                   o_fifo_wr,
	output scope_pkg::frame_t      o_frame,
	output logic                   o_idle
);
	import scope_pkg::*;

	acq_state_t state;
	len_t       take_len;   // frames requested
	len_t       taken;      // frames written so far
	sample_t    sample0;
	logic       take_ok;

	assign sample0 = i_frame[SAMPLE_W-1:0];
	assign take_ok = !i_fifo_full && (taken < take_len);

	assign o_fifo_wr = (state == ACQ_TAKE) && take_ok;
	assign o_frame   = i_frame;                 // live frame goes in as is
	assign o_idle    = (state == ACQ_IDLE);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state    <= ACQ_IDLE;
			take_len <= '0;
			taken    <= '0;
		end else begin
			case (state)
				ACQ_IDLE: begin
					if (i_arm) begin
						take_len <= i_take_count;
						taken    <= '0;
						if (i_trig_type == TRIG_THRESH) begin
							state <= ACQ_WAIT_LOW;
						end else begin
							state <= ACQ_TAKE;  // no trigger, capture at once
						end
					end
				end

				ACQ_WAIT_LOW: begin
					if (sample0 < TRIG_LOWER) begin
						state <= ACQ_WAIT_HIGH;
					end
				end

				ACQ_WAIT_HIGH: begin
					if (sample0 > TRIG_UPPER) begin
						state <= ACQ_TAKE;  // rising edge through the window
					end
				end

				ACQ_TAKE: begin
					if (take_ok) begin
						taken <= taken + 16'd1;
					end else begin
						state <= ACQ_IDLE;  // count reached or fifo full
					end
				end

				default: begin
					state <= ACQ_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/adc_bank_unpack.sv */
// deinterleaves one ADC bank into ten registered samples; one instance per bank in scope_top
`default_nettype none

module adc_bank_unpack (
	input  wire                                              clk,
	input  wire                                              rstn,
	input  wire scope_pkg::bank_bits_t                       i_bits,
	output scope_pkg::sample_t [scope_pkg::BANK_SAMPLES-1:0] o_samples
);
	import scope_pkg::*;

	sample_t [BANK_SAMPLES-1:0] samples_d;

	// bit b of sample k sits at index 10b+k
	always_comb begin
		for (int k = 0; k < BANK_SAMPLES; k++) begin
			for (int b = 0; b < SAMPLE_W; b++) begin
				samples_d[k][b] = i_bits[BANK_SAMPLES*b + k];
			end
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_samples <= '0;
		end else begin
			o_samples <= samples_d;  // one cycle from bank input
		end
	end

endmodule

`default_nettype wire

/* rtl/scope_pkg.sv */
// shared widths, types, opcodes and frame layout of the scope capture core, imported by each block
`default_nettype none

package scope_pkg;

	// --------------------
	// frame geometry
	localparam int NUM_BANKS     = 4;
	localparam int BANK_SAMPLES  = 10;
	localparam int FRAME_SAMPLES = NUM_BANKS * BANK_SAMPLES;
	localparam int SAMPLE_W      = 12;
	localparam int BANK_BITS     = BANK_SAMPLES * SAMPLE_W;
	localparam int FIFO_DEPTH    = 4;                        // whole frames
	localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);
	localparam int FRAME_WORDS   = FRAME_SAMPLES / 2 + 1;    // sample pairs plus marker
	localparam int WORD_IDX_W    = $clog2(FRAME_WORDS);
	localparam int CMD_BYTES     = 8;

	// --------------------
	// types
	typedef logic signed [SAMPLE_W-1:0]        sample_t;
	typedef logic [BANK_BITS-1:0]              bank_bits_t;
	typedef logic [FRAME_SAMPLES*SAMPLE_W-1:0] frame_t;   // sample 0 in the low bits
	typedef logic [7:0]                        byte_t;
	typedef logic [31:0]                       word_t;
	typedef logic [15:0]                       len_t;

	// --------------------
	// constants and opcodes
	localparam word_t   FRAME_MARKER = {16'hbeef, 16'hdead};
	localparam word_t   FW_VERSION   = 32'd7;
	localparam word_t   UNUSED_REPLY = 32'd19;
	localparam sample_t TRIG_LOWER   = -12'sd10;
	localparam sample_t TRIG_UPPER   = 12'sd10;
	localparam byte_t   TRIG_THRESH  = 8'd1;     // trigger type for the threshold arm

	localparam byte_t OP_READ    = 8'd0;
	localparam byte_t OP_VERSION = 8'd2;
	localparam byte_t OP_UNUSED  = 8'd4;
	localparam byte_t OP_ARM     = 8'd5;

	typedef enum logic [1:0] {ACQ_IDLE, ACQ_WAIT_LOW, ACQ_WAIT_HIGH, ACQ_TAKE} acq_state_t;
	typedef enum logic [1:0] {CMD_RX, CMD_PROCESS, CMD_WAIT} cmd_state_t;
	typedef enum logic [1:0] {TX_IDLE, TX_REPLY, TX_FETCH, TX_WORDS} tx_state_t;

endpackage

`default_nettype wire
